/* sim.f */
+incdir+testbench
src/matrix_geometry_pkg.sv
src/hub75_pkg.sv
src/scan_if.sv
src/timeout.sv
src/brightness_timeout.sv
src/matrix_scan.sv
src/frame_buffer.sv
src/hub75_top.sv
testbench/hub75_tb.sv

/* src/brightness_timeout.sv */
////////////////////////////////////////////////////////////
// output enable timer, holds the row lit for the weight of
// the active bit-plane times the unit display time
////////////////////////////////////////////////////////////
`timescale 1ns/100ps

module brightness_timeout
    import hub75_pkg::*;
#(
    parameter int BRIGHTNESS_LEVELS = 4,
    parameter int BRIGHTNESS_UNIT   = 16,
    parameter int PIXEL_WIDTH       = 8
) (
    input  logic        clk_in,
    input  logic        reset,
    input  logic        row_latch,
    input  plane_mask_t mask_active,
    output logic        output_enable,
    output logic        exceeded_overlap_time
);

    // longest period is the msb plane, sized for all planes set
    localparam int MAX_DURATION   = ((2 ** BRIGHTNESS_LEVELS) - 1) * BRIGHTNESS_UNIT;
    localparam int DURATION_BITS  = $clog2(MAX_DURATION + 1);
    // one row shift plus the drain and latch cycles
    localparam int OVERLAP_CYCLES = PIXEL_WIDTH + 2;

    logic [DURATION_BITS-1:0] duration;
    logic [DURATION_BITS-1:0] remaining;

    // one-hot mask value is the plane weight
    assign duration = DURATION_BITS'(mask_active) * DURATION_BITS'(BRIGHTNESS_UNIT);

    // mask_active is sampled at the latch edge, before the
    // scanner updates it, so the first latch after reset is dark
    always_ff @(posedge clk_in) begin
        if (reset) begin
            remaining <= '0;
        end else if (row_latch) begin
            remaining <= duration;
        end else if (remaining != '0) begin
            remaining <= remaining - 1'b1;
        end
    end

    // lit for exactly duration cycles after the latch
    assign output_enable = (remaining != '0);

    // next row may start shifting near the end of a lit period
    assign exceeded_overlap_time = output_enable && (int'(remaining) <= OVERLAP_CYCLES);

endmodule

/* src/frame_buffer.sv */
////////////////////////////////////////////////////////////
// full panel pixel store, written through a req/ack port and
// read one bit-plane at a time for both halves together
////////////////////////////////////////////////////////////
`timescale 1ns/100ps

module frame_buffer
    import matrix_geometry_pkg::*, hub75_pkg::*;
#(
    parameter int PIXEL_WIDTH       = 8,
    parameter int PIXEL_HALFHEIGHT  = 4,
    parameter int BRIGHTNESS_LEVELS = 4
) (
    input  logic                                  clk_in,
    input  logic                                  reset,
    input  logic                                  wr_req,
    output logic                                  wr_ack,
    input  logic [$clog2(2*PIXEL_HALFHEIGHT)-1:0] wr_row,
    input  logic [$clog2(PIXEL_WIDTH)-1:0]        wr_col,
    input  rgb_t                                  wr_rgb,
    scan_if.memory                                scan
);

    localparam int FULL_HEIGHT   = 2 * PIXEL_HALFHEIGHT;
    localparam int FULL_ROW_BITS = $clog2(FULL_HEIGHT);

    // row-major, top half first then bottom half
    rgb_t pixels [0:FULL_HEIGHT-1][0:PIXEL_WIDTH-1];

    logic [FULL_ROW_BITS-1:0] top_row;
    logic [FULL_ROW_BITS-1:0] bottom_row;
    logic                     wr_strobe;

    // picks the bit of each channel named by the one-hot mask
    // a zero mask gives black
    function automatic rgb_bits_t select_plane(input rgb_t pixel, input plane_mask_t mask);
        rgb_bits_t bits;
        bits = '0;
        for (int i = 0; i < BRIGHTNESS_LEVELS; i++) begin
            if (mask[i]) begin
                bits.r = pixel.r[i];
                bits.g = pixel.g[i];
                bits.b = pixel.b[i];
            end
        end
        return bits;
    endfunction

    // four-phase handshake, ack follows req by one cycle
    always_ff @(posedge clk_in) begin
        if (reset) begin
            wr_ack <= 1'b0;
        end else begin
            wr_ack <= wr_req;
        end
    end

    // store once per handshake, on the req-high ack-low cycle
    assign wr_strobe = wr_req && !wr_ack;

    always_ff @(posedge clk_in) begin
        if (wr_strobe) begin
            pixels[wr_row][wr_col] <= wr_rgb;
        end
    end

    // bottom half shares the row address, offset by a half
    assign top_row    = FULL_ROW_BITS'(scan.row_address);
    assign bottom_row = top_row + FULL_ROW_BITS'(PIXEL_HALFHEIGHT);

    // registered read, bits line up with the scanner's pixel strobe
    // held between rows so the last column stays on the lines
    always_ff @(posedge clk_in) begin
        if (scan.load_en) begin
            scan.rgb_top    <= select_plane(pixels[top_row][scan.column_address],
                                            scan.plane_mask);
            scan.rgb_bottom <= select_plane(pixels[bottom_row][scan.column_address],
                                            scan.plane_mask);
        end
    end

endmodule

/* src/hub75_pkg.sv */
////////////////////////////////////////////////////////////
// scan sequencer state encoding and bit-plane mask type,
// shared by the scanner, the frame buffer and the OE timer
////////////////////////////////////////////////////////////
package hub75_pkg;

    import matrix_geometry_pkg::*;

    // row scan sequence
    //   idle     wait for the display period to reach overlap
    //   load     shift one row of columns out
    //   drain    last pixel strobe of the row
    //   wait_oe  hold until the lit row goes dark
    //   latch    one-cycle row latch pulse
    typedef enum logic [2:0] {
        SCAN_IDLE,
        SCAN_LOAD,
        SCAN_DRAIN,
        SCAN_WAIT_OE,
        SCAN_LATCH
    } scan_state_t;

    // one-hot bit-plane select, msb is the heaviest plane
    // all zero means nothing has been displayed yet
    typedef logic [DEF_BRIGHTNESS_LEVELS-1:0] plane_mask_t;

endpackage

/* src/hub75_top.sv */
////////////////////////////////////////////////////////////
// HUB75 panel driver top, pixel write port in and panel
// signals out; output enable is active high here
////////////////////////////////////////////////////////////
`timescale 1ns/100ps

module hub75_top
    import matrix_geometry_pkg::*, hub75_pkg::*;
#(
    parameter int PIXEL_WIDTH       = DEF_PIXEL_WIDTH,
    parameter int PIXEL_HALFHEIGHT  = DEF_PIXEL_HALFHEIGHT,
    parameter int BRIGHTNESS_LEVELS = DEF_BRIGHTNESS_LEVELS,
    parameter int BRIGHTNESS_UNIT   = DEF_BRIGHTNESS_UNIT
) (
    input  logic                                  clk_in,
    input  logic                                  reset,
    // pixel write port, row spans the full panel height
    input  logic                                  wr_req,
    output logic                                  wr_ack,
    input  logic [$clog2(2*PIXEL_HALFHEIGHT)-1:0] wr_row,
    input  logic [$clog2(PIXEL_WIDTH)-1:0]        wr_col,
    input  logic [DEF_BRIGHTNESS_LEVELS-1:0]      wr_r,
    input  logic [DEF_BRIGHTNESS_LEVELS-1:0]      wr_g,
    input  logic [DEF_BRIGHTNESS_LEVELS-1:0]      wr_b,
    // panel side, top half on 0 and bottom half on 1
    output logic                                  r0,
    output logic                                  g0,
    output logic                                  b0,
    output logic                                  r1,
    output logic                                  g1,
    output logic                                  b1,
    output logic                                  clk_pixel,
    output logic                                  row_latch,
    output logic [$clog2(PIXEL_HALFHEIGHT)-1:0]   row_address_active,
    output logic                                  output_enable
);

    rgb_t        wr_rgb;
    plane_mask_t mask_active;
    logic        exceeded_overlap_time;

    scan_if #(
        .PIXEL_WIDTH     (PIXEL_WIDTH),
        .PIXEL_HALFHEIGHT(PIXEL_HALFHEIGHT)
    ) scan ();

    assign wr_rgb = '{r: wr_r, g: wr_g, b: wr_b};

    matrix_scan #(
        .PIXEL_WIDTH      (PIXEL_WIDTH),
        .PIXEL_HALFHEIGHT (PIXEL_HALFHEIGHT),
        .BRIGHTNESS_LEVELS(BRIGHTNESS_LEVELS)
    ) u_scan (
        .clk_in               (clk_in),
        .reset                (reset),
        .scan                 (scan.scanner),
        .output_enable        (output_enable),
        .exceeded_overlap_time(exceeded_overlap_time),
        .clk_pixel            (clk_pixel),
        .row_latch            (row_latch),
        .row_address_active   (row_address_active),
        .mask_active          (mask_active)
    );

    frame_buffer #(
        .PIXEL_WIDTH      (PIXEL_WIDTH),
        .PIXEL_HALFHEIGHT (PIXEL_HALFHEIGHT),
        .BRIGHTNESS_LEVELS(BRIGHTNESS_LEVELS)
    ) u_frame_buffer (
        .clk_in(clk_in),
        .reset (reset),
        .wr_req(wr_req),
        .wr_ack(wr_ack),
        .wr_row(wr_row),
        .wr_col(wr_col),
        .wr_rgb(wr_rgb),
        .scan  (scan.memory)
    );

    brightness_timeout #(
        .BRIGHTNESS_LEVELS(BRIGHTNESS_LEVELS),
        .BRIGHTNESS_UNIT  (BRIGHTNESS_UNIT),
        .PIXEL_WIDTH      (PIXEL_WIDTH)
    ) u_brightness (
        .clk_in               (clk_in),
        .reset                (reset),
        .row_latch            (row_latch),
        .mask_active          (mask_active),
        .output_enable        (output_enable),
        .exceeded_overlap_time(exceeded_overlap_time)
    );

    // colour bits straight from the frame buffer read registers
    assign r0 = scan.rgb_top.r;
    assign g0 = scan.rgb_top.g;
    assign b0 = scan.rgb_top.b;
    assign r1 = scan.rgb_bottom.r;
    assign g1 = scan.rgb_bottom.g;
    assign b1 = scan.rgb_bottom.b;

endmodule

/* src/matrix_geometry_pkg.sv */
////////////////////////////////////////////////////////////
// panel geometry defaults and pixel colour types,
// imported wherever a pixel or its bit-plane slice is held
////////////////////////////////////////////////////////////
package matrix_geometry_pkg;

    // columns per row, shared by both halves
    localparam int DEF_PIXEL_WIDTH = 8;
    // rows per half, one row address drives two physical rows
    localparam int DEF_PIXEL_HALFHEIGHT = 4;
    // bits per colour channel, one bit-plane each
    localparam int DEF_BRIGHTNESS_LEVELS = 4;
    // display cycles for the weight-1 plane
    localparam int DEF_BRIGHTNESS_UNIT = 16;

    // full colour pixel as stored in the frame buffer
    typedef struct packed {
        logic [DEF_BRIGHTNESS_LEVELS-1:0] r;
        logic [DEF_BRIGHTNESS_LEVELS-1:0] g;
        logic [DEF_BRIGHTNESS_LEVELS-1:0] b;
    } rgb_t;

    // one bit-plane of one pixel, i.e. what one panel half shifts in
    typedef struct packed {
        logic r;
        logic g;
        logic b;
    } rgb_bits_t;

endpackage

/* src/matrix_scan.sv */
////////////////////////////////////////////////////////////
// row, column and bit-plane sequencer, shifts each row out
// while the previous one is lit and latches it when dark
////////////////////////////////////////////////////////////
`timescale 1ns/100ps

module matrix_scan
    import hub75_pkg::*;
#(
    parameter int PIXEL_WIDTH       = 8,
    parameter int PIXEL_HALFHEIGHT  = 4,
    parameter int BRIGHTNESS_LEVELS = 4
) (
    input  logic                                clk_in,
    input  logic                                reset,
    scan_if.scanner                             scan,
    input  logic                                output_enable,
    input  logic                                exceeded_overlap_time,
    output logic                                clk_pixel,
    output logic                                row_latch,
    output logic [$clog2(PIXEL_HALFHEIGHT)-1:0] row_address_active,
    output plane_mask_t                         mask_active
);

    localparam int COL_BITS  = $clog2(PIXEL_WIDTH);
    // one extra bit so the full width fits as a count
    localparam int LOAD_BITS = COL_BITS + 1;
    localparam int ROW_BITS  = $clog2(PIXEL_HALFHEIGHT);
    // heaviest plane is shown first
    localparam plane_mask_t PLANE_MSB = plane_mask_t'(1 << (BRIGHTNESS_LEVELS - 1));

    scan_state_t state;
    scan_state_t next_state;
    logic        state_advance;
    logic        start_load;
    logic        column_running;

    // next row may start once dark or near the end of the period
    assign state_advance = !output_enable || exceeded_overlap_time;

    // kicks both timers, load begins the cycle after
    assign start_load = (state == SCAN_IDLE) && state_advance;

    // load enable, high for exactly PIXEL_WIDTH cycles
    timeout #(
        .COUNTER_WIDTH(LOAD_BITS)
    ) u_load_timeout (
        .clk_in (clk_in),
        .reset  (reset),
        .start  (start_load),
        .value  (LOAD_BITS'(PIXEL_WIDTH)),
        .counter(),
        .running(scan.load_en)
    );

    // column address, PIXEL_WIDTH-1 down to 0 in step with load_en
    timeout #(
        .COUNTER_WIDTH(COL_BITS)
    ) u_column_timeout (
        .clk_in (clk_in),
        .reset  (reset),
        .start  (start_load),
        .value  (COL_BITS'(PIXEL_WIDTH - 1)),
        .counter(scan.column_address),
        .running(column_running)
    );

    always_comb begin
        next_state = state;
        case (state)
            SCAN_IDLE: begin
                if (state_advance) begin
                    next_state = SCAN_LOAD;
                end
            end
            SCAN_LOAD: begin
                // column 0 is the last load cycle
                if (!column_running) begin
                    next_state = SCAN_DRAIN;
                end
            end
            SCAN_DRAIN: begin
                next_state = SCAN_WAIT_OE;
            end
            SCAN_WAIT_OE: begin
                // never latch into a lit row
                if (!output_enable) begin
                    next_state = SCAN_LATCH;
                end
            end
            SCAN_LATCH: begin
                next_state = SCAN_IDLE;
            end
            default: begin
                next_state = SCAN_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk_in) begin
        if (reset) begin
            state     <= SCAN_IDLE;
            clk_pixel <= 1'b0;
            row_latch <= 1'b0;
        end else begin
            state     <= next_state;
            // strobe trails the read address by the memory latency
            clk_pixel <= scan.load_en;
            // high while in SCAN_LATCH
            row_latch <= (state == SCAN_WAIT_OE) && !output_enable;
        end
    end

    // plane and row stepping at each latch
    always_ff @(posedge clk_in) begin
        if (reset) begin
            scan.plane_mask    <= PLANE_MSB;
            scan.row_address   <= '0;
            mask_active        <= '0;
            row_address_active <= '0;
        end else if (row_latch) begin
            // the row just shifted becomes the lit one
            mask_active        <= scan.plane_mask;
            row_address_active <= scan.row_address;
            if (scan.plane_mask[0]) begin
                // past the lsb, back to the msb of the next row
                scan.plane_mask <= PLANE_MSB;
                if (scan.row_address == ROW_BITS'(PIXEL_HALFHEIGHT - 1)) begin
                    scan.row_address <= '0;
                end else begin
                    scan.row_address <= scan.row_address + 1'b1;
                end
            end else begin
                scan.plane_mask <= scan.plane_mask >> 1;
            end
        end
    end

endmodule

/* src/scan_if.sv */
////////////////////////////////////////////////////////////
// scan position and load strobe from scanner to frame buffer,
// with the bit-plane colour bits of both halves coming back
////////////////////////////////////////////////////////////
`timescale 1ns/100ps

interface scan_if
    import matrix_geometry_pkg::*, hub75_pkg::*;
#(
    parameter int PIXEL_WIDTH      = 8,
    parameter int PIXEL_HALFHEIGHT = 4
);

    // column counts down, last column leaves the panel first
    logic [$clog2(PIXEL_WIDTH)-1:0]      column_address;
    logic [$clog2(PIXEL_HALFHEIGHT)-1:0] row_address;
    plane_mask_t                         plane_mask;
    // high for each load cycle of a row
    logic                                load_en;

    // registered read, one cycle behind the address
    rgb_bits_t                           rgb_top;
    rgb_bits_t                           rgb_bottom;

    modport scanner (
        output column_address,
        output row_address,
        output plane_mask,
        output load_en
    );

    modport memory (
        input  column_address,
        input  row_address,
        input  plane_mask,
        input  load_en,
        output rgb_top,
        output rgb_bottom
    );

endinterface

/* src/timeout.sv */
////////////////////////////////////////////////////////////
// loadable down-counter with a running flag, used for the
// row load enable and the column address of the scanner
////////////////////////////////////////////////////////////
`timescale 1ns/100ps

module timeout #(
    parameter int COUNTER_WIDTH = 4
) (
    input  logic                     clk_in,
    input  logic                     reset,
    input  logic                     start,
    input  logic [COUNTER_WIDTH-1:0] value,
    output logic [COUNTER_WIDTH-1:0] counter,
    output logic                     running
);

    // start wins over the count, so a restart reloads mid-run
    always_ff @(posedge clk_in) begin
        if (reset) begin
            counter <= '0;
        end else if (start) begin
            counter <= value;
        end else if (counter != '0) begin
            // one step per cycle, parks at zero
            counter <= counter - 1'b1;
        end
    end

    // high from the cycle after start until the count empties
    assign running = (counter != '0);

endmodule

/* testbench/hub75_model.svh */
////////////////////////////////////////////////////////////
// reference model of the frame, scan order and display
// weights, plus the compare tasks; included by hub75_tb
////////////////////////////////////////////////////////////
`ifndef HUB75_MODEL_SVH
`define HUB75_MODEL_SVH

// mirror of every pixel written through the port
rgb_t model_frame [0:2*HALF_H-1][0:WIDTH-1];

// row and plane the scanner shifts out next
int exp_row   = 0;
int exp_plane = LEVELS - 1;

// one bit-plane slice of a stored pixel
function automatic rgb_bits_t model_bits(input int row, input int col, input int plane);
    rgb_t      px;
    rgb_bits_t bits;
    px     = model_frame[row][col];
    bits.r = px.r[plane];
    bits.g = px.g[plane];
    bits.b = px.b[plane];
    return bits;
endfunction

// heaviest plane first, next row once past the lsb
function automatic void advance_scan();
    if (exp_plane == 0) begin
        exp_plane = LEVELS - 1;
        exp_row   = (exp_row + 1) % HALF_H;
    end else begin
        exp_plane = exp_plane - 1;
    end
endfunction

task automatic check_bits(input string name, input rgb_bits_t expected,
                          input rgb_bits_t actual);
    if (actual !== expected) begin
        stop_run($sformatf("** Error %s expected %b actual %b", name, expected, actual));
    end
endtask

task automatic check_row(input string name, input row_t expected, input row_t actual);
    if (actual !== expected) begin
        stop_run($sformatf("** Error %s expected %0d actual %0d", name, expected, actual));
    end
endtask

task automatic check_mask(input string name, input plane_mask_t expected,
                          input plane_mask_t actual);
    if (actual !== expected) begin
        stop_run($sformatf("** Error %s expected %b actual %b", name, expected, actual));
    end
endtask

// single panel or handshake line
task automatic check_flag(input string name, input logic expected, input logic actual);
    if (actual !== expected) begin
        stop_run($sformatf("** Error %s expected %b actual %b", name, expected, actual));
    end
endtask

task automatic check_count(input string name, input int expected, input int actual);
    if (actual != expected) begin
        stop_run($sformatf("** Error %s expected %0d actual %0d", name, expected, actual));
    end
endtask

`endif

/* testbench/hub75_tb.sv */
////////////////////////////////////////////////////////////
// testbench for hub75_top, writes a random frame and checks
// the shifted bits, latch order and display times
////////////////////////////////////////////////////////////
`timescale 1ns/100ps

module hub75_tb
    import matrix_geometry_pkg::*, hub75_pkg::*;
;

    localparam int WIDTH    = DEF_PIXEL_WIDTH;
    localparam int HALF_H   = DEF_PIXEL_HALFHEIGHT;
    localparam int LEVELS   = DEF_BRIGHTNESS_LEVELS;
    localparam int UNIT     = DEF_BRIGHTNESS_UNIT;
    localparam int ROW_BITS = $clog2(HALF_H);
    localparam int WR_ROW_BITS = $clog2(2 * HALF_H);
    localparam int COL_BITS    = $clog2(WIDTH);
    localparam int RESET_CYCLES = 10;
    localparam int REWRITES     = 20;
    // four cycles per handshake
    localparam int WRITE_CYCLES = (2 * HALF_H * WIDTH + REWRITES) * 4;
    localparam int SCAN_CYCLES  =
        2 * HALF_H * LEVELS * (((1 << LEVELS) - 1) * UNIT + WIDTH + 8);
    localparam int TIMEOUT_CYCLES = RESET_CYCLES + WRITE_CYCLES + SCAN_CYCLES + 500;
    // two full frames of checked rows
    localparam int TARGET_LOADS = 2 * HALF_H * LEVELS;

    typedef logic [ROW_BITS-1:0] row_t;

    logic                              clk_in;
    logic                              reset;
    logic                              wr_req;
    logic                              wr_ack;
    logic [WR_ROW_BITS-1:0]            wr_row;
    logic [COL_BITS-1:0]               wr_col;
    logic [LEVELS-1:0]                 wr_r;
    logic [LEVELS-1:0]                 wr_g;
    logic [LEVELS-1:0]                 wr_b;
    logic                              r0;
    logic                              g0;
    logic                              b0;
    logic                              r1;
    logic                              g1;
    logic                              b1;
    logic                              clk_pixel;
    logic                              row_latch;
    row_t                              row_address_active;
    logic                              output_enable;

    // monitor state
    bit   writes_done   = 1'b0;
    bit   overlap_seen  = 1'b0;
    bit   prev_pixel    = 1'b0;
    bit   load_checked  = 1'b0;
    bit   latch_seen    = 1'b0;
    int   pix_count     = 0;
    int   checked_loads = 0;
    int   oe_len        = 0;
    int   expected_len  = 0;
    int   prev_weight   = 0;
    int   latched_row   = 0;
    int   latched_plane = 0;
    int   cycle_count   = 0;
    int   col;

    task automatic stop_run(input string line);
        $display("%s", line);
        $display("Checks failed");
        $fatal(1, "run stopped at first error");
    endtask

    `include "hub75_model.svh"

    hub75_top u_dut (
        .clk_in(clk_in), .reset(reset),
        .wr_req(wr_req), .wr_ack(wr_ack), .wr_row(wr_row), .wr_col(wr_col),
        .wr_r(wr_r), .wr_g(wr_g), .wr_b(wr_b),
        .r0(r0), .g0(g0), .b0(b0), .r1(r1), .g1(g1), .b1(b1),
        .clk_pixel(clk_pixel), .row_latch(row_latch),
        .row_address_active(row_address_active), .output_enable(output_enable)
    );

    initial begin
        clk_in = 1'b0;
        forever #4 clk_in = ~clk_in;
    end

    // outputs that must sit at their reset values
    task automatic check_reset_state(input string name);
        check_flag({name, " clk_pixel"}, 1'b0, clk_pixel);
        check_flag({name, " row_latch"}, 1'b0, row_latch);
        check_flag({name, " output_enable"}, 1'b0, output_enable);
        check_flag({name, " wr_ack"}, 1'b0, wr_ack);
        check_row({name, " row_address_active"}, '0, row_address_active);
    endtask

    // one four-phase write, latency of each leg counted
    task automatic write_pixel(input int row, input int col_w, input rgb_t px);
        int lat;
        model_frame[row][col_w] = px;
        wr_req <= 1'b1;
        wr_row <= WR_ROW_BITS'(row);
        wr_col <= COL_BITS'(col_w);
        wr_r   <= px.r;
        wr_g   <= px.g;
        wr_b   <= px.b;
        lat = 0;
        @(posedge clk_in);
        while (!wr_ack) begin
            lat++;
            @(posedge clk_in);
        end
        check_count("ack rise latency", 1, lat);
        wr_req <= 1'b0;
        lat = 0;
        @(posedge clk_in);
        while (wr_ack) begin
            lat++;
            @(posedge clk_in);
        end
        check_count("ack fall latency", 1, lat);
    endtask

    initial begin
        rgb_t px;
        reset  = 1'b1;
        wr_req = 1'b0;
        wr_row = '0;
        wr_col = '0;
        wr_r   = '0;
        wr_g   = '0;
        wr_b   = '0;
        void'($urandom(94));
        repeat (RESET_CYCLES) @(posedge clk_in);
        reset <= 1'b0;
        check_reset_state("in reset");
        @(posedge clk_in);
        check_reset_state("first cycle after reset");
        @(posedge clk_in);
        check_reset_state("second cycle after reset");
        // whole panel, then random overwrites
        for (int r = 0; r < 2 * HALF_H; r++) begin
            for (int c = 0; c < WIDTH; c++) begin
                px = rgb_t'($urandom_range((1 << (3 * LEVELS)) - 1));
                write_pixel(r, c, px);
            end
        end
        for (int i = 0; i < REWRITES; i++) begin
            px = rgb_t'($urandom_range((1 << (3 * LEVELS)) - 1));
            write_pixel($urandom_range(2 * HALF_H - 1), $urandom_range(WIDTH - 1), px);
        end
        // seen by the monitor from the next edge on
        writes_done <= 1'b1;
        while (checked_loads < TARGET_LOADS) @(posedge clk_in);
        if (!overlap_seen) begin
            stop_run("Error: no pixel strobe was seen while output enable was high");
        end else begin
            $display("All checks passed");
            $finish;
        end
    end

    // panel monitor, sees the values of the cycle just ended
    always @(posedge clk_in) begin
        if (reset) begin
            prev_pixel = 1'b0;
            latch_seen = 1'b0;
            oe_len     = 0;
        end else begin
            // display period length
            if (output_enable) begin
                oe_len++;
            end else if (oe_len != 0) begin
                check_count("display time", expected_len, oe_len);
                oe_len = 0;
            end
            // state just after a latch
            if (latch_seen) begin
                check_row("active row", row_t'(latched_row), row_address_active);
                check_mask("active mask", plane_mask_t'(1 << latched_plane),
                           u_dut.mask_active);
                if ((expected_len != 0) != output_enable) begin
                    stop_run("Error: output enable did not follow the row latch as expected");
                end
                latch_seen = 1'b0;
            end
            if (row_latch) begin
                if (output_enable) begin
                    stop_run("Error: row latch while output enable was high");
                end
                latched_row   = exp_row;
                latched_plane = exp_plane;
                // timer takes the weight latched one step earlier
                expected_len  = prev_weight * UNIT;
                prev_weight   = 1 << exp_plane;
                advance_scan();
                latch_seen    = 1'b1;
            end
            // shifted colour bits, last column first
            if (clk_pixel) begin
                if (!prev_pixel) begin
                    pix_count    = 0;
                    load_checked = writes_done;
                end
                if (load_checked) begin
                    col = WIDTH - 1 - pix_count;
                    check_bits($sformatf("top row %0d plane %0d col %0d",
                                         exp_row, exp_plane, col),
                               model_bits(exp_row, col, exp_plane),
                               rgb_bits_t'({r0, g0, b0}));
                    check_bits($sformatf("bottom row %0d plane %0d col %0d",
                                         exp_row + HALF_H, exp_plane, col),
                               model_bits(exp_row + HALF_H, col, exp_plane),
                               rgb_bits_t'({r1, g1, b1}));
                end
                pix_count++;
                if (output_enable) begin
                    overlap_seen = 1'b1;
                end
            end else if (prev_pixel) begin
                check_count("pixels per row", WIDTH, pix_count);
                if (load_checked) begin
                    checked_loads++;
                end
            end
            prev_pixel = clk_pixel;
        end
    end

    // run limit from the write and scan lengths
    always @(posedge clk_in) begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            stop_run("Error: timeout, the scan did not finish the checked rows in time");
        end
    end

endmodule
